// ==== source/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [31:0] word_t;      // data, address, instruction
  typedef logic [4:0]  reg_num_t;   // register number
  typedef logic [3:0]  alu_ctrl_t;  // alu operation
  typedef logic [1:0]  fwd_sel_t;   // operand source in decode
  typedef logic [1:0]  pc_src_t;    // next pc select

  // major opcodes
  localparam logic [5:0] OP_RTYPE = 6'b000000;
  localparam logic [5:0] OP_ADDI  = 6'b001000;
  localparam logic [5:0] OP_ANDI  = 6'b001100;
  localparam logic [5:0] OP_ORI   = 6'b001101;
  localparam logic [5:0] OP_XORI  = 6'b001110;
  localparam logic [5:0] OP_LUI   = 6'b001111;
  localparam logic [5:0] OP_LW    = 6'b100011;
  localparam logic [5:0] OP_SW    = 6'b101011;
  localparam logic [5:0] OP_BEQ   = 6'b000100;
  localparam logic [5:0] OP_BNE   = 6'b000101;
  localparam logic [5:0] OP_J     = 6'b000010;
  localparam logic [5:0] OP_JAL   = 6'b000011;

  // r-type function field
  localparam logic [5:0] FN_ADD = 6'b100000;
  localparam logic [5:0] FN_SUB = 6'b100010;
  localparam logic [5:0] FN_AND = 6'b100100;
  localparam logic [5:0] FN_OR  = 6'b100101;
  localparam logic [5:0] FN_XOR = 6'b100110;
  localparam logic [5:0] FN_SLL = 6'b000000;
  localparam logic [5:0] FN_SRL = 6'b000010;
  localparam logic [5:0] FN_SRA = 6'b000011;
  localparam logic [5:0] FN_JR  = 6'b001000;

  localparam alu_ctrl_t ALU_ADD = 4'b0000;
  localparam alu_ctrl_t ALU_SUB = 4'b0100;
  localparam alu_ctrl_t ALU_AND = 4'b0001;
  localparam alu_ctrl_t ALU_OR  = 4'b0101;
  localparam alu_ctrl_t ALU_XOR = 4'b0010;
  localparam alu_ctrl_t ALU_LUI = 4'b0110;
  localparam alu_ctrl_t ALU_SLL = 4'b0011;
  localparam alu_ctrl_t ALU_SRL = 4'b0111;
  localparam alu_ctrl_t ALU_SRA = 4'b1111;

  localparam fwd_sel_t FWD_REG  = 2'd0;  // register file
  localparam fwd_sel_t FWD_EALU = 2'd1;  // alu result in exe
  localparam fwd_sel_t FWD_MALU = 2'd2;  // alu result in mem
  localparam fwd_sel_t FWD_MMO  = 2'd3;  // load data in mem

  localparam pc_src_t PC_SEQ    = 2'd0;
  localparam pc_src_t PC_BRANCH = 2'd1;
  localparam pc_src_t PC_REG    = 2'd2;
  localparam pc_src_t PC_JUMP   = 2'd3;

  localparam reg_num_t LINK_REG = 5'd31;  // jal return address

  localparam int DMEM_DEPTH = 64;  // data memory words
  localparam int DMEM_AW    = 6;   // word index bits above byte offset

endpackage

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     clrn,
  input  reg_num_t i_rna,  // read port a
  input  reg_num_t i_rnb,  // read port b
  input  reg_num_t i_wn,   // write port
  input  logic     i_we,
  input  word_t    i_wd,
  output word_t    o_qa,
  output word_t    o_qb
);

  word_t regs [32];
  logic  wr_ok;

  assign wr_ok = i_we && (i_wn != '0);  // r0 is never written

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      for (int k = 0; k < 32; k++) regs[k] <= '0;
    end else if (wr_ok) begin
      regs[i_wn] <= i_wd;
    end
  end

  // same-cycle write shows through to the readers
  assign o_qa = (wr_ok && i_wn == i_rna) ? i_wd : regs[i_rna];
  assign o_qb = (wr_ok && i_wn == i_rnb) ? i_wd : regs[i_rnb];

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; (
  input  logic    clk,
  input  logic    clrn,
  input  word_t   i_inst,    // instruction at o_pc, same cycle
  input  logic    i_hold,    // load-use stall from decode
  input  pc_src_t i_pc_src,
  input  word_t   i_bpc,     // branch target
  input  word_t   i_rpc,     // jr target
  input  word_t   i_jpc,     // j/jal target
  output word_t   o_pc,
  output word_t   o_pc4_d,   // pc+4 in decode stage
  output word_t   o_inst_d   // instruction in decode stage
);

  word_t pc4;
  word_t npc;

  assign pc4 = o_pc + 32'd4;

  always_comb begin
    case (i_pc_src)
      PC_BRANCH: npc = i_bpc;
      PC_REG:    npc = i_rpc;
      PC_JUMP:   npc = i_jpc;
      default:   npc = pc4;  // sequential
    endcase
  end

  // pc and if/id register both freeze on a stall
  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      o_pc     <= '0;
      o_pc4_d  <= '0;
      o_inst_d <= '0;  // nop
    end else if (!i_hold) begin
      o_pc     <= npc;
      o_pc4_d  <= pc4;
      o_inst_d <= i_inst;
    end
  end

endmodule

// ==== source/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit import cpu_pkg::*; (
  input  logic      clk,
  input  logic      clrn,
  input  word_t     i_inst,     // from if/id
  input  word_t     i_pc4,      // delay slot address
  input  reg_num_t  i_ern,      // exe destination
  input  reg_num_t  i_mrn,      // mem destination
  input  reg_num_t  i_wrn,      // wb destination
  input  logic      i_ewreg,
  input  logic      i_em2reg,   // load in exe
  input  logic      i_mwreg,
  input  logic      i_mm2reg,   // load in mem
  input  logic      i_wwreg,
  input  word_t     i_ealu,
  input  word_t     i_malu,
  input  word_t     i_mmo,
  input  word_t     i_wdi,      // write-back data
  output logic      o_hold,     // load-use stall
  output pc_src_t   o_pc_src,
  output word_t     o_bpc,
  output word_t     o_jpc,
  output word_t     o_a,        // forwarded rs, also jr target
  output word_t     o_b,        // forwarded rt
  output word_t     o_imm,
  output reg_num_t  o_rn,
  output alu_ctrl_t o_aluc,
  output logic      o_wreg,
  output logic      o_m2reg,
  output logic      o_wmem,
  output logic      o_aluimm,
  output logic      o_shift,
  output logic      o_jal
);

  logic [5:0] op, fn;
  reg_num_t   rs, rt, rd;
  word_t      qa, qb;
  fwd_sel_t   fwd_a, fwd_b;
  logic       rtype, is_add, is_sub, is_and, is_or, is_xor, is_sll, is_srl, is_sra, is_jr;
  logic       is_addi, is_andi, is_ori, is_xori, is_lui, is_lw, is_sw;
  logic       is_beq, is_bne, is_j, is_jal;
  logic       use_rs, use_rt, writes, regrt, sext, equal;

  // newest producer wins, r0 never forwarded
  function automatic fwd_sel_t fwd_select(reg_num_t src);
    fwd_sel_t sel;
    sel = FWD_REG;
    if (src != '0) begin
      if (i_ewreg && !i_em2reg && i_ern == src) sel = FWD_EALU;
      else if (i_mwreg && i_mrn == src) sel = i_mm2reg ? FWD_MMO : FWD_MALU;
    end
    return sel;
  endfunction

  function automatic word_t pick(fwd_sel_t sel, word_t q);
    case (sel)
      FWD_EALU: return i_ealu;
      FWD_MALU: return i_malu;
      FWD_MMO:  return i_mmo;
      default:  return q;
    endcase
  endfunction

  assign op = i_inst[31:26];
  assign fn = i_inst[5:0];
  assign rs = i_inst[25:21];
  assign rt = i_inst[20:16];
  assign rd = i_inst[15:11];

  assign rtype   = (op == OP_RTYPE);
  assign is_add  = rtype && fn == FN_ADD;
  assign is_sub  = rtype && fn == FN_SUB;
  assign is_and  = rtype && fn == FN_AND;
  assign is_or   = rtype && fn == FN_OR;
  assign is_xor  = rtype && fn == FN_XOR;
  assign is_sll  = rtype && fn == FN_SLL;
  assign is_srl  = rtype && fn == FN_SRL;
  assign is_sra  = rtype && fn == FN_SRA;
  assign is_jr   = rtype && fn == FN_JR;
  assign is_addi = (op == OP_ADDI);
  assign is_andi = (op == OP_ANDI);
  assign is_ori  = (op == OP_ORI);
  assign is_xori = (op == OP_XORI);
  assign is_lui  = (op == OP_LUI);
  assign is_lw   = (op == OP_LW);
  assign is_sw   = (op == OP_SW);
  assign is_beq  = (op == OP_BEQ);
  assign is_bne  = (op == OP_BNE);
  assign is_j    = (op == OP_J);
  assign is_jal  = (op == OP_JAL);

  assign use_rs = is_add | is_sub | is_and | is_or | is_xor | is_jr | is_addi | is_andi |
                  is_ori | is_xori | is_lw | is_sw | is_beq | is_bne;
  assign use_rt = is_add | is_sub | is_and | is_or | is_xor | is_sll | is_srl | is_sra |
                  is_sw | is_beq | is_bne;
  assign writes = is_add | is_sub | is_and | is_or | is_xor | is_sll | is_srl | is_sra |
                  is_addi | is_andi | is_ori | is_xori | is_lui | is_lw | is_jal;
  assign regrt  = is_addi | is_andi | is_ori | is_xori | is_lui | is_lw;  // dest in rt
  assign sext   = is_addi | is_lw | is_sw | is_beq | is_bne;

  // load in exe feeding this instruction, wait one cycle
  assign o_hold = i_ewreg && i_em2reg && (i_ern != '0) &&
                  ((use_rs && i_ern == rs) || (use_rt && i_ern == rt));

  always_comb begin
    fwd_a = fwd_select(rs);
    fwd_b = fwd_select(rt);
    o_a   = pick(fwd_a, qa);
    o_b   = pick(fwd_b, qb);
  end

  assign equal = (o_a == o_b);  // branch compare on forwarded operands

  always_comb begin
    if (is_jr) o_pc_src = PC_REG;
    else if (is_j || is_jal) o_pc_src = PC_JUMP;
    else if ((is_beq && equal) || (is_bne && !equal)) o_pc_src = PC_BRANCH;
    else o_pc_src = PC_SEQ;
  end

  always_comb begin
    if (is_sub) o_aluc = ALU_SUB;
    else if (is_and || is_andi) o_aluc = ALU_AND;
    else if (is_or || is_ori) o_aluc = ALU_OR;
    else if (is_xor || is_xori) o_aluc = ALU_XOR;
    else if (is_lui) o_aluc = ALU_LUI;
    else if (is_sll) o_aluc = ALU_SLL;
    else if (is_srl) o_aluc = ALU_SRL;
    else if (is_sra) o_aluc = ALU_SRA;
    else o_aluc = ALU_ADD;  // add, addi, lw, sw
  end

  assign o_imm    = {{16{sext & i_inst[15]}}, i_inst[15:0]};
  assign o_bpc    = i_pc4 + {o_imm[29:0], 2'b00};       // relative to delay slot
  assign o_jpc    = {i_pc4[31:28], i_inst[25:0], 2'b00};
  assign o_rn     = regrt ? rt : rd;
  assign o_wreg   = writes & ~o_hold;  // bubble on stall
  assign o_wmem   = is_sw & ~o_hold;
  assign o_m2reg  = is_lw;
  assign o_aluimm = is_addi | is_andi | is_ori | is_xori | is_lui | is_lw | is_sw;
  assign o_shift  = is_sll | is_srl | is_sra;
  assign o_jal    = is_jal;

  reg_file u_reg_file (
    .clk   (clk),
    .clrn  (clrn),
    .i_rna (rs),
    .i_rnb (rt),
    .i_wn  (i_wrn),
    .i_we  (i_wwreg),
    .i_wd  (i_wdi),
    .o_qa  (qa),
    .o_qb  (qb)
  );

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit import cpu_pkg::*; (
  input  logic      clk,
  input  logic      clrn,
  input  word_t     i_a,
  input  word_t     i_b,
  input  word_t     i_imm,
  input  reg_num_t  i_rn,
  input  alu_ctrl_t i_aluc,
  input  logic      i_wreg,
  input  logic      i_m2reg,
  input  logic      i_wmem,
  input  logic      i_aluimm,
  input  logic      i_shift,
  input  logic      i_jal,
  input  word_t     i_pc4,     // pc+4 of the decode instruction
  output word_t     o_ealu,
  output reg_num_t  o_ern,
  output logic      o_ewreg,
  output logic      o_em2reg,
  output logic      o_ewmem,
  output word_t     o_eb       // store data
);

  word_t     e_a, e_imm, e_pc4;
  reg_num_t  e_rn;
  alu_ctrl_t e_aluc;
  logic      e_aluimm, e_shift, e_jal;
  word_t     alu_a, alu_b, alu_out;

  // id/exe register
  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      o_ewreg  <= 1'b0;
      o_em2reg <= 1'b0;
      o_ewmem  <= 1'b0;
      e_aluimm <= 1'b0;
      e_shift  <= 1'b0;
      e_jal    <= 1'b0;
      e_aluc   <= ALU_ADD;
      e_rn     <= '0;
      e_a      <= '0;
      o_eb     <= '0;
      e_imm    <= '0;
      e_pc4    <= '0;
    end else begin
      o_ewreg  <= i_wreg;
      o_em2reg <= i_m2reg;
      o_ewmem  <= i_wmem;
      e_aluimm <= i_aluimm;
      e_shift  <= i_shift;
      e_jal    <= i_jal;
      e_aluc   <= i_aluc;
      e_rn     <= i_rn;
      e_a      <= i_a;
      o_eb     <= i_b;
      e_imm    <= i_imm;
      e_pc4    <= i_pc4;
    end
  end

  assign alu_a = e_shift ? {27'd0, e_imm[10:6]} : e_a;  // sa field for shifts
  assign alu_b = e_aluimm ? e_imm : o_eb;

  always_comb begin
    case (e_aluc)
      ALU_ADD: alu_out = alu_a + alu_b;
      ALU_SUB: alu_out = alu_a - alu_b;
      ALU_AND: alu_out = alu_a & alu_b;
      ALU_OR:  alu_out = alu_a | alu_b;
      ALU_XOR: alu_out = alu_a ^ alu_b;
      ALU_LUI: alu_out = {alu_b[15:0], 16'h0000};
      ALU_SLL: alu_out = alu_b << alu_a[4:0];
      ALU_SRL: alu_out = alu_b >> alu_a[4:0];
      ALU_SRA: alu_out = $signed(alu_b) >>> alu_a[4:0];
      default: alu_out = '0;
    endcase
  end

  // jal links pc+8 into r31
  assign o_ealu = e_jal ? e_pc4 + 32'd4 : alu_out;
  assign o_ern  = e_jal ? LINK_REG : e_rn;

endmodule

// ==== source/memory_unit.sv ====
`timescale 1ns/1ps

module memory_unit import cpu_pkg::*; (
  input  logic     clk,
  input  logic     clrn,
  input  word_t    i_ealu,
  input  word_t    i_eb,
  input  reg_num_t i_ern,
  input  logic     i_ewreg,
  input  logic     i_em2reg,
  input  logic     i_ewmem,
  output word_t    o_malu,   // mem stage alu result, also store address
  output word_t    o_mmo,    // load data
  output reg_num_t o_mrn,
  output logic     o_mwreg,
  output logic     o_mm2reg,
  output logic     o_mwmem,
  output word_t    o_mb,     // store data
  output word_t    o_wdi,    // write-back data
  output reg_num_t o_wrn,
  output logic     o_wwreg
);

  word_t              dmem [DMEM_DEPTH];
  logic [DMEM_AW-1:0] dm_idx;
  word_t              w_mo, w_alu;
  logic               w_m2reg;

  // exe/mem register
  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      o_mwreg  <= 1'b0;
      o_mm2reg <= 1'b0;
      o_mwmem  <= 1'b0;
      o_malu   <= '0;
      o_mb     <= '0;
      o_mrn    <= '0;
    end else begin
      o_mwreg  <= i_ewreg;
      o_mm2reg <= i_em2reg;
      o_mwmem  <= i_ewmem;
      o_malu   <= i_ealu;
      o_mb     <= i_eb;
      o_mrn    <= i_ern;
    end
  end

  assign dm_idx = o_malu[DMEM_AW+1:2];  // word index

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      for (int k = 0; k < DMEM_DEPTH; k++) dmem[k] <= '0;
    end else if (o_mwmem) begin
      dmem[dm_idx] <= o_mb;
    end
  end

  assign o_mmo = dmem[dm_idx];  // async read

  // mem/wb register
  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      o_wwreg <= 1'b0;
      w_m2reg <= 1'b0;
      w_mo    <= '0;
      w_alu   <= '0;
      o_wrn   <= '0;
    end else begin
      o_wwreg <= o_mwreg;
      w_m2reg <= o_mm2reg;
      w_mo    <= o_mmo;
      w_alu   <= o_malu;
      o_wrn   <= o_mrn;
    end
  end

  assign o_wdi = w_m2reg ? w_mo : w_alu;  // load data or alu result

endmodule

// ==== source/mips_pipeline.sv ====
`timescale 1ns/1ps

module mips_pipeline import cpu_pkg::*; (
  input  logic     clk,
  input  logic     clrn,
  input  word_t    i_inst,      // instruction word at o_pc
  output word_t    o_pc,
  output logic     o_wb_we,
  output reg_num_t o_wb_rn,
  output word_t    o_wb_data,
  output logic     o_mem_we,
  output word_t    o_mem_addr,
  output word_t    o_mem_wdata
);

  word_t     pc4_d, inst_d, bpc, jpc, d_a, d_b, d_imm, ealu, eb, mmo;
  pc_src_t   pc_src;
  logic      hold, d_wreg, d_m2reg, d_wmem, d_aluimm, d_shift, d_jal;
  logic      ewreg, em2reg, ewmem, mwreg, mm2reg;
  reg_num_t  d_rn, ern, mrn;
  alu_ctrl_t d_aluc;

  fetch_unit u_fetch (
    .clk(clk), .clrn(clrn), .i_inst(i_inst), .i_hold(hold), .i_pc_src(pc_src),
    .i_bpc(bpc), .i_rpc(d_a), .i_jpc(jpc),                  // jr target is forwarded rs
    .o_pc(o_pc), .o_pc4_d(pc4_d), .o_inst_d(inst_d)
  );

  decode_unit u_decode (
    .clk(clk), .clrn(clrn), .i_inst(inst_d), .i_pc4(pc4_d),
    .i_ern(ern), .i_mrn(mrn), .i_wrn(o_wb_rn), .i_ewreg(ewreg), .i_em2reg(em2reg),
    .i_mwreg(mwreg), .i_mm2reg(mm2reg), .i_wwreg(o_wb_we),
    .i_ealu(ealu), .i_malu(o_mem_addr), .i_mmo(mmo), .i_wdi(o_wb_data),
    .o_hold(hold), .o_pc_src(pc_src), .o_bpc(bpc), .o_jpc(jpc), .o_a(d_a), .o_b(d_b),
    .o_imm(d_imm), .o_rn(d_rn), .o_aluc(d_aluc), .o_wreg(d_wreg), .o_m2reg(d_m2reg),
    .o_wmem(d_wmem), .o_aluimm(d_aluimm), .o_shift(d_shift), .o_jal(d_jal)
  );

  execute_unit u_execute (
    .clk(clk), .clrn(clrn), .i_a(d_a), .i_b(d_b), .i_imm(d_imm), .i_rn(d_rn),
    .i_aluc(d_aluc), .i_wreg(d_wreg), .i_m2reg(d_m2reg), .i_wmem(d_wmem),
    .i_aluimm(d_aluimm), .i_shift(d_shift), .i_jal(d_jal), .i_pc4(pc4_d),
    .o_ealu(ealu), .o_ern(ern), .o_ewreg(ewreg), .o_em2reg(em2reg), .o_ewmem(ewmem),
    .o_eb(eb)
  );

  memory_unit u_memory (
    .clk(clk), .clrn(clrn), .i_ealu(ealu), .i_eb(eb), .i_ern(ern), .i_ewreg(ewreg),
    .i_em2reg(em2reg), .i_ewmem(ewmem),
    .o_malu(o_mem_addr), .o_mmo(mmo), .o_mrn(mrn), .o_mwreg(mwreg), .o_mm2reg(mm2reg),
    .o_mwmem(o_mem_we), .o_mb(o_mem_wdata),                 // store port seen at top
    .o_wdi(o_wb_data), .o_wrn(o_wb_rn), .o_wwreg(o_wb_we)
  );

endmodule

// ==== sim/mips_pipeline_asserts.sv ====
`timescale 1ns/1ps

module mips_pipeline_asserts import cpu_pkg::*; (
  input logic  clk,
  input logic  clrn,
  input word_t i_pc,
  input logic  i_hold,    // load-use stall
  input logic  i_wb_we,
  input logic  i_mem_we
);

  int n_failed = 0;  // read by the testbench summary

  a_pc_aligned: assert property (@(posedge clk) disable iff (!clrn) i_pc[1:0] == 2'b00)
    else begin
      $error("pc %h is not word aligned", i_pc);
      n_failed++;
    end

  // no write may leak out while reset holds
  a_quiet_in_reset: assert property (@(posedge clk) !clrn |-> !i_wb_we && !i_mem_we)
    else begin
      $error("write enable high during reset");
      n_failed++;
    end

  a_pc_held: assert property (@(posedge clk) disable iff (!clrn) i_hold |=> $stable(i_pc))
    else begin
      $error("pc moved during a load-use stall");
      n_failed++;
    end

endmodule

bind mips_pipeline mips_pipeline_asserts u_asserts (
  .clk(clk), .clrn(clrn), .i_pc(o_pc), .i_hold(hold),
  .i_wb_we(o_wb_we), .i_mem_we(o_mem_we)
);

// ==== sim/tb_mips_pipeline.sv ====
`timescale 1ns/1ps

module tb_mips_pipeline import cpu_pkg::*; ();

  logic     clk;
  logic     clrn;
  word_t    i_inst;
  word_t    o_pc;
  logic     o_wb_we;
  reg_num_t o_wb_rn;
  word_t    o_wb_data;
  logic     o_mem_we;
  word_t    o_mem_addr;
  word_t    o_mem_wdata;

  word_t       imem [256];     // program image, word indexed
  int          n_inst;         // words emitted so far
  word_t       halt_pc;        // address of the final jump to itself
  string       cur_test;
  reg_num_t    exp_rn [$];     // expected write-back order
  word_t       exp_wd [$];
  word_t       exp_addr [$];   // expected stores
  word_t       exp_data [$];
  int          n_err = 0;
  int          n_wb = 0;
  int          n_st = 0;
  int unsigned cyc_now = 0;
  int unsigned deadline = 1000;

  mips_pipeline UUT (
    .clk(clk), .clrn(clrn), .i_inst(i_inst), .o_pc(o_pc),
    .o_wb_we(o_wb_we), .o_wb_rn(o_wb_rn), .o_wb_data(o_wb_data),
    .o_mem_we(o_mem_we), .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // instruction memory answers the current pc
  always @(posedge clk) begin
    #5;
    i_inst = imem[o_pc[9:2]];
  end

  function automatic word_t enc_r(logic [5:0] fn, reg_num_t rd, reg_num_t rs, reg_num_t rt,
                                  logic [4:0] sa);
    return {OP_RTYPE, rs, rt, rd, sa, fn};
  endfunction

  function automatic word_t enc_i(logic [5:0] op, reg_num_t rt, reg_num_t rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t enc_j(logic [5:0] op, int idx);
    return {op, 26'(idx)};  // target is a word index, program starts at 0
  endfunction

  // architectural model, one delay slot after every transfer
  function automatic void run_ref();
    word_t      r [32];
    word_t      m [DMEM_DEPTH];
    word_t      pc, npc, tgt, inst, a, b, res, imm_s, imm_z, addr;
    logic [5:0] op, fn;
    reg_num_t   rs, rt, rd, dst;
    logic       wr, halt;
    for (int k = 0; k < 32; k++) r[k] = '0;
    for (int k = 0; k < DMEM_DEPTH; k++) m[k] = '0;
    pc = '0;
    npc = 32'd4;
    for (int step = 0; step < 4000; step++) begin
      inst  = imem[pc[9:2]];
      op    = inst[31:26];
      fn    = inst[5:0];
      rs    = inst[25:21];
      rt    = inst[20:16];
      rd    = inst[15:11];
      a     = r[rs];
      b     = r[rt];
      imm_s = {{16{inst[15]}}, inst[15:0]};
      imm_z = {16'h0000, inst[15:0]};
      wr    = 1'b0;
      halt  = 1'b0;
      dst   = rt;  // i-type default
      res   = '0;
      tgt   = npc + 32'd4;
      case (op)
        OP_RTYPE: begin
          wr  = 1'b1;
          dst = rd;
          case (fn)
            FN_ADD:  res = a + b;
            FN_SUB:  res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_XOR:  res = a ^ b;
            FN_SLL:  res = b << inst[10:6];
            FN_SRL:  res = b >> inst[10:6];
            FN_SRA:  res = $signed(b) >>> inst[10:6];
            FN_JR: begin
              wr  = 1'b0;
              tgt = a;
            end
            default: wr = 1'b0;
          endcase
        end
        OP_ADDI: begin
          wr  = 1'b1;
          res = a + imm_s;
        end
        OP_ANDI: begin
          wr  = 1'b1;
          res = a & imm_z;
        end
        OP_ORI: begin
          wr  = 1'b1;
          res = a | imm_z;
        end
        OP_XORI: begin
          wr  = 1'b1;
          res = a ^ imm_z;
        end
        OP_LUI: begin
          wr  = 1'b1;
          res = {inst[15:0], 16'h0000};
        end
        OP_LW: begin
          addr = a + imm_s;
          wr   = 1'b1;
          res  = m[addr[7:2]];
        end
        OP_SW: begin
          addr = a + imm_s;
          m[addr[7:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        OP_BEQ: if (a == b) tgt = pc + 32'd4 + (imm_s << 2);  // from the delay slot
        OP_BNE: if (a != b) tgt = pc + 32'd4 + (imm_s << 2);
        OP_J: begin
          tgt  = {pc[31:28], inst[25:0], 2'b00};
          halt = (tgt == pc);
        end
        OP_JAL: begin
          tgt = {pc[31:28], inst[25:0], 2'b00};
          wr  = 1'b1;
          dst = LINK_REG;
          res = pc + 32'd8;  // skip the delay slot
        end
        default: ;
      endcase
      if (wr && dst != '0) begin
        r[dst] = res;
        exp_rn.push_back(dst);
        exp_wd.push_back(res);
      end
      if (halt) break;  // slot after the halt is a nop
      pc  = npc;
      npc = tgt;
    end
  endfunction

  task automatic check_word(string what, word_t exp, word_t act);
    if (exp !== act) begin
      n_err++;
      $display("Fail %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_reg(string what, reg_num_t exp, reg_num_t act);
    if (exp !== act) begin
      n_err++;
      $display("Fail %s %s: expected r%0d actual r%0d", cur_test, what, exp, act);
    end
  endtask

  // results sampled mid-cycle, away from the write edge
  always @(negedge clk) begin
    if (clrn && o_wb_we && o_wb_rn != '0) begin
      n_wb++;
      if (exp_rn.size() == 0) begin
        n_err++;
        $display("%s: register r%0d written when no write was expected", cur_test, o_wb_rn);
      end else begin
        check_reg("write-back register", exp_rn.pop_front(), o_wb_rn);
        check_word("write-back data", exp_wd.pop_front(), o_wb_data);
      end
    end
    if (clrn && o_mem_we) begin
      n_st++;
      if (exp_addr.size() == 0) begin
        n_err++;
        $display("%s: store to %h when no store was expected", cur_test, o_mem_addr);
      end else begin
        check_word("store address", exp_addr.pop_front(), o_mem_addr);
        check_word("store data", exp_data.pop_front(), o_mem_wdata);
      end
    end
  end

  initial begin : watchdog
    while (cyc_now <= deadline) begin
      @(posedge clk);
      cyc_now++;
    end
    $display("timeout: %s never reached its final jump", cur_test);
    $display("Something failed");
    $finish;
  end

  task automatic begin_prog(string name);
    @(posedge clk);
    #5;
    clrn = 1'b0;  // clears pipeline, registers and data memory
    cur_test = name;
    n_inst = 0;
    for (int k = 0; k < 256; k++) imem[k] = '0;  // all nops
  endtask

  task automatic emit(word_t w);
    imem[n_inst] = w;
    n_inst++;
  endtask

  task automatic run_prog();
    halt_pc = word_t'(n_inst * 4);
    emit(enc_j(OP_J, n_inst));  // spin here
    emit('0);
    exp_rn.delete();
    exp_wd.delete();
    exp_addr.delete();
    exp_data.delete();
    run_ref();
    deadline = cyc_now + 40 * n_inst + 100;
    repeat (3) @(posedge clk);
    #5;
    clrn = 1'b1;
    while (o_pc !== halt_pc) begin
      @(posedge clk);
      #5;
    end
    repeat (8) @(posedge clk);  // let the last instructions retire
    #5;
    if (exp_rn.size() != 0 || exp_addr.size() != 0) begin
      n_err++;
      $display("%s: %0d register writes and %0d stores never happened", cur_test,
               exp_rn.size(), exp_addr.size());
    end
  endtask

  task automatic prog_alu_chain();
    begin_prog("alu_chain");
    emit(enc_i(OP_ADDI, 1, 0, 16'd5));
    emit(enc_i(OP_ADDI, 2, 1, 16'd7));      // exe forward
    emit(enc_r(FN_ADD, 3, 1, 2, 0));        // exe and mem
    emit(enc_r(FN_SUB, 4, 3, 1, 0));
    emit(enc_r(FN_AND, 5, 4, 3, 0));
    emit(enc_r(FN_OR, 6, 5, 2, 0));
    emit(enc_r(FN_XOR, 7, 6, 4, 0));
    emit(enc_r(FN_SLL, 8, 0, 7, 5'd3));
    emit(enc_r(FN_SRL, 9, 0, 8, 5'd2));
    emit(enc_i(OP_LUI, 10, 0, 16'h8001));
    emit(enc_r(FN_SRA, 11, 0, 10, 5'd4));   // sign fill
    emit(enc_i(OP_ORI, 12, 11, 16'h1234));
    emit(enc_i(OP_ANDI, 13, 12, 16'hff0f));
    emit(enc_i(OP_XORI, 14, 13, 16'hffff)); // zero extended
    emit(enc_i(OP_ADDI, 15, 14, 16'hffff)); // minus one
    emit(enc_r(FN_ADD, 16, 15, 15, 0));
    emit(enc_r(FN_ADD, 17, 14, 15, 0));     // one from wb bypass
    emit(enc_i(OP_ADDI, 0, 17, 16'd1));     // r0 stays zero
    emit(enc_r(FN_ADD, 18, 0, 17, 0));
    run_prog();
  endtask

  task automatic prog_load_use();
    begin_prog("load_use");
    emit(enc_i(OP_ADDI, 1, 0, 16'h0055));
    emit(enc_i(OP_SW, 1, 0, 16'd8));
    emit(enc_i(OP_LW, 2, 0, 16'd8));
    emit(enc_r(FN_ADD, 3, 2, 2, 0));        // stall then load forward
    emit(enc_i(OP_LW, 4, 0, 16'd8));
    emit(enc_i(OP_SW, 4, 0, 16'd12));       // store data from a load
    emit(enc_i(OP_LW, 5, 0, 16'd12));
    emit(enc_i(OP_ADDI, 6, 5, 16'd1));
    emit(enc_i(OP_LW, 7, 0, 16'd12));
    emit('0);
    emit(enc_r(FN_SUB, 8, 7, 1, 0));        // load data from mem stage
    run_prog();
  endtask

  task automatic prog_store_load();
    begin_prog("store_load");
    emit(enc_i(OP_ADDI, 1, 0, 16'h0011));
    emit(enc_i(OP_LUI, 2, 0, 16'habcd));
    emit(enc_i(OP_ORI, 2, 2, 16'h1234));
    emit(enc_i(OP_SW, 1, 0, 16'd0));
    emit(enc_i(OP_SW, 2, 0, 16'd4));
    emit(enc_i(OP_SW, 1, 0, 16'd252));      // top word
    emit(enc_i(OP_LW, 3, 0, 16'd4));
    emit(enc_i(OP_LW, 4, 0, 16'd0));
    emit(enc_i(OP_SW, 3, 0, 16'd0));        // overwrite
    emit(enc_i(OP_LW, 5, 0, 16'd0));
    emit(enc_i(OP_LW, 6, 0, 16'd252));
    emit(enc_i(OP_LW, 7, 0, 16'd16));       // never written
    emit(enc_i(OP_ADDI, 8, 0, 16'd8));
    emit(enc_i(OP_SW, 2, 8, 16'd8));        // base register plus offset
    emit(enc_i(OP_LW, 9, 0, 16'd16));
    run_prog();
  endtask

  task automatic prog_branches();
    begin_prog("branches");
    emit(enc_i(OP_ADDI, 1, 0, 16'd1));
    emit(enc_i(OP_ADDI, 2, 0, 16'd1));
    emit(enc_i(OP_BEQ, 2, 1, 16'd2));       // taken, r2 from exe
    emit(enc_i(OP_ADDI, 3, 0, 16'd3));      // delay slot
    emit(enc_i(OP_ADDI, 4, 0, 16'd4));      // skipped
    emit(enc_i(OP_BNE, 2, 1, 16'd2));       // not taken
    emit(enc_i(OP_ADDI, 5, 0, 16'd5));
    emit(enc_i(OP_ADDI, 6, 0, 16'd6));
    emit(enc_i(OP_BNE, 0, 1, 16'd2));       // taken
    emit(enc_i(OP_ADDI, 7, 0, 16'd7));
    emit(enc_i(OP_ADDI, 8, 0, 16'd8));      // skipped
    emit(enc_i(OP_BEQ, 0, 1, 16'd2));       // not taken
    emit(enc_i(OP_ADDI, 9, 0, 16'd9));
    emit(enc_i(OP_ADDI, 10, 0, 16'd10));
    emit(enc_i(OP_LW, 11, 0, 16'd0));
    emit(enc_i(OP_BEQ, 0, 11, 16'd2));      // waits on the load
    emit(enc_i(OP_ADDI, 12, 0, 16'd12));
    emit(enc_i(OP_ADDI, 13, 0, 16'd13));    // skipped
    emit(enc_j(OP_J, n_inst + 3));
    emit(enc_i(OP_ADDI, 14, 0, 16'd14));
    emit(enc_i(OP_ADDI, 15, 0, 16'd15));    // skipped
    emit(enc_i(OP_ADDI, 16, 0, 16'd16));
    run_prog();
  endtask

  task automatic prog_jal_jr();
    begin_prog("jal_jr");
    emit(enc_i(OP_ADDI, 1, 0, 16'd1));
    emit(enc_j(OP_JAL, 6));
    emit(enc_i(OP_ADDI, 2, 0, 16'd2));      // delay slot
    emit(enc_i(OP_ADDI, 3, 0, 16'd3));      // return point, jal pc+8
    emit(enc_j(OP_J, 9));
    emit('0);
    emit(enc_i(OP_ADDI, 4, 31, 16'd0));     // subroutine reads the link
    emit(enc_r(FN_JR, 0, 31, 0, 0));
    emit(enc_i(OP_ADDI, 5, 0, 16'd5));
    run_prog();
  endtask

  function automatic word_t rand_inst();
    reg_num_t rd, rs, rt;
    int       kind;
    rd   = reg_num_t'($urandom_range(0, 7));  // few registers, many hazards
    rs   = reg_num_t'($urandom_range(0, 7));
    rt   = reg_num_t'($urandom_range(0, 7));
    kind = $urandom_range(0, 14);
    case (kind)
      0:  return enc_r(FN_ADD, rd, rs, rt, 0);
      1:  return enc_r(FN_SUB, rd, rs, rt, 0);
      2:  return enc_r(FN_AND, rd, rs, rt, 0);
      3:  return enc_r(FN_OR, rd, rs, rt, 0);
      4:  return enc_r(FN_XOR, rd, rs, rt, 0);
      5:  return enc_r(FN_SLL, rd, 0, rt, 5'($urandom));
      6:  return enc_r(FN_SRL, rd, 0, rt, 5'($urandom));
      7:  return enc_r(FN_SRA, rd, 0, rt, 5'($urandom));
      8:  return enc_i(OP_ADDI, rt, rs, 16'($urandom));
      9:  return enc_i(OP_ANDI, rt, rs, 16'($urandom));
      10: return enc_i(OP_ORI, rt, rs, 16'($urandom));
      11: return enc_i(OP_XORI, rt, rs, 16'($urandom));
      12: return enc_i(OP_LUI, rt, 0, 16'($urandom));
      13: return enc_i(OP_LW, rt, 0, 16'($urandom_range(0, 15) * 4));  // small window
      default: return enc_i(OP_SW, rt, 0, 16'($urandom_range(0, 15) * 4));
    endcase
  endfunction

  initial begin
    int len;
    clrn   = 1'b0;
    i_inst = '0;
    void'($urandom(32'h82a4f757));
    prog_alu_chain();
    prog_load_use();
    prog_store_load();
    prog_branches();
    prog_jal_jr();
    for (int p = 0; p < 200; p++) begin
      begin_prog($sformatf("random_%0d", p));
      len = $urandom_range(8, 24);
      repeat (len) emit(rand_inst());
      run_prog();
    end
    $display("write-backs %0d, stores %0d, errors %0d, assertion failures %0d",
             n_wb, n_st, n_err, UUT.u_asserts.n_failed);
    if (n_err == 0 && UUT.u_asserts.n_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
source/cpu_pkg.sv
source/reg_file.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/memory_unit.sv
source/mips_pipeline.sv
sim/mips_pipeline_asserts.sv
sim/tb_mips_pipeline.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  - source/cpu_pkg.sv
  - source/reg_file.sv
  - source/fetch_unit.sv
  - source/decode_unit.sv
  - source/execute_unit.sv
  - source/memory_unit.sv
  - source/mips_pipeline.sv
  - target: test
    files:
      - sim/mips_pipeline_asserts.sv
      - sim/tb_mips_pipeline.sv
